/* compile.f */
src/ksMicroPkg.sv
src/ksMemPkg.sv
src/vmaControl.sv
src/vmaRegister.sv
src/memCycleRegister.sv
src/vmaUnit.sv
sim/vmaUnit_sva.sv
sim/vmaUnitTb.sv

/* run.sh */
#!/bin/sh
# Build and run the VMA stage testbench with Verilator
cd "$(dirname "$0")" || exit 1
rm -rf obj_dir build.log sim.log
verilator --binary --timing --assert -f compile.f --top-module vmaUnitTb -o vmaUnitTb \
   > build.log 2>&1 || { cat build.log; echo "Build failed"; exit 1; }
./obj_dir/vmaUnitTb > sim.log 2>&1
cat sim.log
grep -q "^TEST PASSED$" sim.log && echo "Simulation passed" || { echo "Simulation failed"; exit 1; }

/* sim/vmaUnitTb.sv */
// VMA stage testbench: clock, reset, directed and random stimulus, reference model, compare
`timescale 1ns/1ps

module vmaUnitTb;

   import ksMicroPkg::*;
   import ksMemPkg::*;

   localparam int randomCycles = 2000;
   localparam int waitLimit    = 50;
   localparam int watchdogNs   = 40000;

   // All stage outputs side by side
   typedef struct packed {
      logic     sweep;
      logic     extended;
      vmaFlagsT flags;
      vmaAddrT  addr;
   } vmaOutT;

   logic        clk;
   logic        rst;
   logic        clken;
   cromT        crom;
   dromT        drom;
   dpWordT      dp;
   logic        cpuExec;
   logic        prevEn;
   logic [0:17] pcFlags;
   logic        vmaSweep;
   logic        vmaExtended;
   vmaFlagsT    vmaFlags;
   vmaAddrT     vmaAddr;

   string testName;
   int    stimCount;
   int    checkCount;

   vmaUnit u_dut
   (
      .clk         (clk),
      .rst         (rst),
      .clken       (clken),
      .crom        (crom),
      .drom        (drom),
      .dp          (dp),
      .cpuExec     (cpuExec),
      .prevEn      (prevEn),
      .pcFlags     (pcFlags),
      .vmaSweep    (vmaSweep),
      .vmaExtended (vmaExtended),
      .vmaFlags    (vmaFlags),
      .vmaAddr     (vmaAddr)
   );

   // 4 ns clock
   initial
   begin
      clk = 1'b0;
      forever
      begin
         #2 clk = ~clk;
      end
   end

   //////////////////////////////////////////////////////////////////////
   // Reference model and checking
   //////////////////////////////////////////////////////////////////////

   // Next register contents from the previous ones and the sampled inputs
   function automatic vmaOutT predictNext(vmaOutT prev, logic en, cromT c, dromT d,
                                          dpWordT w, logic exec, logic pEn,
                                          logic [0:17] pcf);
      vmaOutT nxt;
      logic   clrCache;
      logic   prevSel;
      logic   pcUser;
      logic   pcPrevUser;
      nxt        = prev;
      clrCache   = c.spec.specEn20 && (c.spec.specSel == specClrCache);
      prevSel    = c.spec.specEn20 && (c.spec.specSel == specPrevious);
      pcUser     = pcf[flagUserBit];
      pcPrevUser = pcf[flagPcuBit];
      if (en && ((c.mem.memCycle && (c.mem.loadVma || (c.mem.aRead && d.vma))) || clrCache))
      begin
         nxt.addr     = w.raw[14:35];
         nxt.sweep    = clrCache;
         nxt.extended = c.mem.extAddr;
         if (c.mem.dpFunc)
         begin
            // Flag bits 0, 2 and 8 to 13 straight off the data path
            {nxt.flags.user, nxt.flags.fetch} = {w.raw[0], w.raw[2]};
            {nxt.flags.physical, nxt.flags.previous} = w.raw[8:9];
            {nxt.flags.ioCycle, nxt.flags.wruCycle} = w.raw[10:11];
            {nxt.flags.vectorCycle, nxt.flags.ioByteCycle} = w.raw[12:13];
         end
         else
         begin
            nxt.flags.user = (!c.mem.forceExec && pcUser && !exec) ||
                             (c.mem.fetchCycle && pcUser) || (pEn && pcPrevUser) ||
                             (prevSel && pcPrevUser) || c.mem.forceUser;
            nxt.flags.fetch       = c.mem.fetchCycle;
            nxt.flags.physical    = c.mem.physical;
            nxt.flags.previous    = pEn || prevSel;
            nxt.flags.ioCycle     = 1'b0;
            nxt.flags.wruCycle    = 1'b0;
            nxt.flags.vectorCycle = 1'b0;
            nxt.flags.ioByteCycle = 1'b0;
         end
      end
      if (en && c.mem.memCycle && (c.mem.memWait || (c.mem.bWrite && d.condFunc)))
      begin
         // Order is read, write-test, write, cache inhibit
         case ({c.mem.aRead, c.mem.dpFunc})
            2'b11:   {nxt.flags.readCycle, nxt.flags.wrTestCycle, nxt.flags.writeCycle,
                      nxt.flags.cacheInh} = {d.readCycle, d.wrTestCycle, d.writeCycle, 1'b0};
            2'b10:   {nxt.flags.readCycle, nxt.flags.wrTestCycle, nxt.flags.writeCycle,
                      nxt.flags.cacheInh} = 4'b0000;
            2'b01:   {nxt.flags.readCycle, nxt.flags.wrTestCycle, nxt.flags.writeCycle,
                      nxt.flags.cacheInh} = {w.raw[3:5], w.raw[7]};
            default: {nxt.flags.readCycle, nxt.flags.wrTestCycle, nxt.flags.writeCycle,
                      nxt.flags.cacheInh} = {c.mem.readCycle, c.mem.wrTestCycle,
                                             c.mem.writeCycle, c.mem.cacheInh};
         endcase
      end
      return nxt;
   endfunction

   task automatic checkEq(input string name, input string what, input logic [35:0] expected,
                          input logic [35:0] actual);
      if (actual !== expected)
      begin
         $display("[ERROR] %s %s: expected %h, actual %h", name, what, expected, actual);
         $display("TEST FAILED");
         $fatal(1, "Output mismatch, stopping the run");
      end
   endtask

   // Compare one cycle after each sampling edge
   initial
   begin : compareProc
      vmaOutT expected;
      string  stepName;
      expected = '0;
      forever
      begin
         @(posedge clk);
         stepName = testName;
         if (rst)
            expected = '0;
         else
            expected = predictNext(expected, clken, crom, drom, dp, cpuExec, prevEn, pcFlags);
         #2;
         checkEq(stepName, "vmaSweep", 36'(expected.sweep), 36'(vmaSweep));
         checkEq(stepName, "vmaExtended", 36'(expected.extended), 36'(vmaExtended));
         checkEq(stepName, "vmaFlags", 36'(expected.flags), 36'(vmaFlags));
         checkEq(stepName, "vmaAddr", 36'(expected.addr), 36'(vmaAddr));
         if (!rst)
            checkCount++;
      end
   end

   //////////////////////////////////////////////////////////////////////
   // Stimulus
   //////////////////////////////////////////////////////////////////////

   // Next drive point, 1 ns after the rising edge
   task automatic waitDrive(input string name);
      @(posedge clk);
      #1;
      testName = name;
      stimCount++;
   endtask

   task automatic randomizeInputs;
      logic [31:0] r;
      logic [63:0] wide;
      r       = $urandom;
      crom    = r[21:0];
      r       = $urandom;
      drom    = r[4:0];
      cpuExec = r[5];
      prevEn  = r[6];
      clken   = r[7];
      pcFlags = r[25:8];
      wide    = {$urandom, $urandom};
      dp      = wide[35:0];
   endtask

   initial
   begin : mainProc
      int waited;
      void'($urandom(32'hb195));
      testName   = "reset";
      stimCount  = 0;
      checkCount = 0;
      rst        = 1'b1;
      clken      = 1'b0;
      crom       = '0;
      drom       = '0;
      dp         = '0;
      cpuExec    = 1'b0;
      prevEn     = 1'b0;
      pcFlags    = '0;
      repeat (5) @(posedge clk);
      #1;
      rst = 1'b0;

      // Enable low, then enabled with nothing requested
      for (int i = 0; i < 16; i++)
      begin
         waitDrive(i < 8 ? "idleClkenLow" : "idleNoLoad");
         randomizeInputs();
         clken = (i >= 8);
         crom.mem.memCycle  = (i < 8) ? crom.mem.memCycle : 1'b0;
         crom.spec.specEn20 = (i < 8) ? crom.spec.specEn20 : 1'b0;
      end
      // Address and flags from the data path
      for (int i = 0; i < 8; i++)
      begin
         waitDrive("loadVmaDp");
         randomizeInputs();
         clken = 1'b1;
         crom.mem.memCycle = 1'b1;
         crom.mem.loadVma  = 1'b1;
         crom.mem.dpFunc   = 1'b1;
      end
      // User derivation terms walked through
      for (int i = 0; i < 32; i++)
      begin
         waitDrive("loadVmaUcode");
         randomizeInputs();
         clken = 1'b1;
         crom.mem.memCycle   = 1'b1;
         crom.mem.loadVma    = 1'b1;
         crom.mem.dpFunc     = 1'b0;
         crom.mem.forceExec  = i[0];
         crom.mem.forceUser  = i[1];
         crom.mem.fetchCycle = i[2];
         prevEn              = i[3];
         crom.spec.specEn20  = i[4];
         crom.spec.specSel   = specPrevious;
      end
      // Each aRead and dpFunc pair, through memWait and then bWrite
      for (int i = 0; i < 24; i++)
      begin
         waitDrive(i < 16 ? "memCycleWait" : "memCycleBWrite");
         randomizeInputs();
         clken = 1'b1;
         crom.mem.memCycle = 1'b1;
         crom.mem.memWait  = (i < 16);
         crom.mem.bWrite   = 1'b1;
         drom.condFunc     = 1'b1;
         crom.mem.aRead    = i[1];
         crom.mem.dpFunc   = i[0];
      end
      // Clear cache loads without memCycle
      for (int i = 0; i < 4; i++)
      begin
         waitDrive("clearCache");
         randomizeInputs();
         clken = 1'b1;
         crom.mem.memCycle  = 1'b0;
         crom.spec.specEn20 = 1'b1;
         crom.spec.specSel  = specClrCache;
      end
      for (int i = 0; i < randomCycles; i++)
      begin
         waitDrive("random");
         randomizeInputs();
      end

      // Let the compare process see the last step
      waited = 0;
      while (checkCount <= stimCount && waited < waitLimit)
      begin
         @(posedge clk);
         #3;
         waited++;
      end
      if (checkCount > stimCount)
      begin
         $display("TEST PASSED");
         $finish;
      end
      else
      begin
         $display("Compare process did not finish checking the last steps in time");
         $display("TEST FAILED");
         $fatal(1, "Timeout waiting for the final checks");
      end
   end

   // Run time limit
   initial
   begin
      #(watchdogNs);
      $display("Simulation ran past its time limit without finishing");
      $display("TEST FAILED");
      $fatal(1, "Watchdog expired");
   end

endmodule

/* sim/vmaUnit_sva.sv */
// Bound assertions for the VMA stage reset value and hold without load
`timescale 1ns/1ps

module vmaUnitSva
(
   input logic               clk,
   input logic               rst,
   input logic               vmaLoad,
   input logic               memLoad,
   input logic               vmaSweep,
   input logic               vmaExtended,
   input ksMemPkg::vmaFlagsT vmaFlags,
   input ksMemPkg::vmaAddrT  vmaAddr
);

   //////////////////////////////////////////////////////////////////////
   // Output properties
   //////////////////////////////////////////////////////////////////////

   // Everything clear while reset is held
   resetClear: assert property (@(posedge clk)
      rst |-> (vmaAddr == '0 && !vmaSweep && !vmaExtended && vmaFlags == '0))
      else $error("VMA outputs not zero during reset");

   // Outputs hold on the edge after a cycle with no load
   holdNoLoad: assert property (@(posedge clk) disable iff (rst)
      (!vmaLoad && !memLoad) |=> $stable({vmaSweep, vmaExtended, vmaFlags, vmaAddr}))
      else $error("VMA outputs changed without a load");

endmodule

bind vmaUnit vmaUnitSva u_sva
(
   .clk         (clk),
   .rst         (rst),
   .vmaLoad     (vmaLoad),
   .memLoad     (memLoad),
   .vmaSweep    (vmaSweep),
   .vmaExtended (vmaExtended),
   .vmaFlags    (vmaFlags),
   .vmaAddr     (vmaAddr)
);

/* src/ksMemPkg.sv */
// Data path word union, VMA flag struct, address type and memory cycle struct
package ksMemPkg;

   // Bit indices into the PC flags, PDP-10 numbering
   localparam int flagUserBit = 5;
   localparam int flagPcuBit  = 6;

   // Virtual address in bits 14 to 35 of the word
   typedef logic [14:35] vmaAddrT;

   //////////////////////////////////////////////////////////////////////
   // VMA flag word
   //////////////////////////////////////////////////////////////////////

   // First member is bit 0, the most significant bit
   typedef struct packed {
      logic user;                // Bit 0
      logic spare1;
      logic fetch;
      logic readCycle;
      logic wrTestCycle;
      logic writeCycle;          // Bit 5
      logic spare6;
      logic cacheInh;
      logic physical;
      logic previous;
      logic ioCycle;             // Bit 10
      logic wruCycle;
      logic vectorCycle;
      logic ioByteCycle;         // Bit 13
   } vmaFlagsT;

   // Data path word seen as flags plus address
   typedef struct packed {
      vmaFlagsT flags;
      vmaAddrT  addr;
   } dpFieldsT;

   // Same 36 bits read as raw data or as a VMA request
   typedef union packed {
      logic [0:35] raw;
      dpFieldsT    fields;
   } dpWordT;

   // Context part of the VMA flags
   typedef struct packed {
      logic user;
      logic fetch;
      logic physical;
      logic previous;
      logic ioCycle;
      logic wruCycle;
      logic vectorCycle;
      logic ioByteCycle;
   } ctxFlagsT;

   // Memory cycle kind
   typedef struct packed {
      logic readCycle;
      logic wrTestCycle;
      logic writeCycle;
      logic cacheInh;
   } memCycleT;

endpackage

/* src/ksMicroPkg.sv */
// Control ROM memory and special fields, dispatch ROM fields, special-function codes
package ksMicroPkg;

   //////////////////////////////////////////////////////////////////////
   // Special function select codes
   //////////////////////////////////////////////////////////////////////

   // Sweep the cache on a clear-cache request
   localparam logic [3:0] specClrCache = 4'd7;
   // Reference the previous context
   localparam logic [3:0] specPrevious = 4'd8;

   //////////////////////////////////////////////////////////////////////
   // Control ROM fields
   //////////////////////////////////////////////////////////////////////

   // Memory field of the microword
   typedef struct packed {
      logic       memCycle;      // Start a memory reference
      logic       loadVma;       // Load the VMA from the data path
      logic       aRead;         // Cycle comes from the dispatch ROM
      logic       memWait;       // Wait for the memory cycle
      logic       bWrite;        // Write at the end of the instruction
      logic       dpFunc;        // Take flags or cycle from the data path
      logic       extAddr;       // Extended addressing
      logic       fetchCycle;    // Instruction fetch
      logic       physical;      // Bypass the pager
      logic       forceExec;     // Force executive context
      logic       forceUser;     // Force user context
      logic       readCycle;
      logic       wrTestCycle;
      logic       writeCycle;
      logic       cacheInh;      // Inhibit the cache
      logic [1:0] spare;
   } cromMemT;

   // Special field of the microword
   typedef struct packed {
      logic       specEn20;      // Enable for the special select
      logic [3:0] specSel;
   } cromSpecT;

   // Portion of the microword this stage decodes
   typedef struct packed {
      cromMemT  mem;
      cromSpecT spec;
   } cromT;

   //////////////////////////////////////////////////////////////////////
   // Dispatch ROM fields
   //////////////////////////////////////////////////////////////////////

   typedef struct packed {
      logic vma;                 // A-read may load the VMA
      logic condFunc;            // Conditional B-write function
      logic readCycle;
      logic wrTestCycle;
      logic writeCycle;
   } dromT;

endpackage

/* src/memCycleRegister.sv */
// Memory cycle type register: read, write-test, write, cache inhibit
`timescale 1ns/1ps

module memCycleRegister
(
   input  logic                 clk,
   input  logic                 rst,
   input  logic                 load,
   input  logic                 fromDp,
   input  ksMemPkg::dpWordT     dp,
   input  ksMemPkg::memCycleT   cycleUcode,
   output ksMemPkg::memCycleT   cycle
);

   import ksMemPkg::*;

   memCycleT cycleDp;
   memCycleT cycleNext;

   //////////////////////////////////////////////////////////////////////
   // Cycle source select
   //////////////////////////////////////////////////////////////////////

   // Data path flag bits 3, 4, 5 and 7
   always_comb
   begin
      cycleDp.readCycle   = dp.fields.flags.readCycle;
      cycleDp.wrTestCycle = dp.fields.flags.wrTestCycle;
      cycleDp.writeCycle  = dp.fields.flags.writeCycle;
      cycleDp.cacheInh    = dp.fields.flags.cacheInh;
   end

   // Microcode value is already resolved between control and dispatch ROM
   assign cycleNext = fromDp ? cycleDp : cycleUcode;

   //////////////////////////////////////////////////////////////////////
   // Register
   //////////////////////////////////////////////////////////////////////

   always_ff @(posedge clk or posedge rst)
   begin
      if (rst)
      begin
         cycle <= '0;
      end
      else if (load)
      begin
         cycle <= cycleNext;
      end
   end

endmodule

/* src/vmaControl.sv */
// VMA stage control decode: load enables, source selects, microcode-derived flags
`timescale 1ns/1ps

module vmaControl
(
   input  ksMicroPkg::cromT     crom,
   input  ksMicroPkg::dromT     drom,
   input  logic                 clken,
   input  logic                 cpuExec,
   input  logic                 prevEn,
   input  logic [0:17]          pcFlags,
   output logic                 vmaLoad,
   output logic                 memLoad,
   output logic                 ctxFromDp,
   output logic                 cycleFromDp,
   output logic                 sweep,
   output logic                 extended,
   output ksMemPkg::ctxFlagsT   ctxUcode,
   output ksMemPkg::memCycleT   cycleUcode
);

   import ksMicroPkg::*;
   import ksMemPkg::*;

   logic selPrevious;
   logic flagUser;
   logic flagPcu;

   // PC flags used for the user derivation
   assign flagUser = pcFlags[flagUserBit];
   assign flagPcu  = pcFlags[flagPcuBit];

   //////////////////////////////////////////////////////////////////////
   // Special function decode
   //////////////////////////////////////////////////////////////////////

   assign sweep       = crom.spec.specEn20 && (crom.spec.specSel == specClrCache);
   assign selPrevious = crom.spec.specEn20 && (crom.spec.specSel == specPrevious);

   // Clear cache loads the VMA even without a memory cycle
   assign vmaLoad = clken && ((crom.mem.memCycle && crom.mem.loadVma) ||
                              (crom.mem.memCycle && crom.mem.aRead && drom.vma) ||
                              sweep);

   assign memLoad = clken && ((crom.mem.memCycle && crom.mem.memWait) ||
                              (crom.mem.memCycle && crom.mem.bWrite && drom.condFunc));

   assign extended  = crom.mem.extAddr;
   assign ctxFromDp = crom.mem.dpFunc;

   //////////////////////////////////////////////////////////////////////
   // Context flags from microcode
   //////////////////////////////////////////////////////////////////////

   always_comb
   begin
      ctxUcode.user = (!crom.mem.forceExec && flagUser && !cpuExec) ||
                      (crom.mem.fetchCycle && flagUser) ||
                      (prevEn && flagPcu) ||
                      (selPrevious && flagPcu) ||
                      crom.mem.forceUser;
      ctxUcode.fetch       = crom.mem.fetchCycle;
      ctxUcode.physical    = crom.mem.physical;
      ctxUcode.previous    = prevEn || selPrevious;
      // No I/O references from microcode
      ctxUcode.ioCycle     = 1'b0;
      ctxUcode.wruCycle    = 1'b0;
      ctxUcode.vectorCycle = 1'b0;
      ctxUcode.ioByteCycle = 1'b0;
   end

   // Data path supplies the cycle only for a plain dpFunc request
   assign cycleFromDp = !crom.mem.aRead && crom.mem.dpFunc;

   always_comb
   begin
      cycleUcode = '0;
      if (crom.mem.aRead)
      begin
         if (crom.mem.dpFunc)
         begin
            // Dispatch cycle, never cache inhibited
            cycleUcode.readCycle   = drom.readCycle;
            cycleUcode.wrTestCycle = drom.wrTestCycle;
            cycleUcode.writeCycle  = drom.writeCycle;
         end
      end
      else
      begin
         cycleUcode.readCycle   = crom.mem.readCycle;
         cycleUcode.wrTestCycle = crom.mem.wrTestCycle;
         cycleUcode.writeCycle  = crom.mem.writeCycle;
         cycleUcode.cacheInh    = crom.mem.cacheInh;
      end
   end

endmodule

/* src/vmaRegister.sv */
// VMA address, sweep, extended and context flag register
`timescale 1ns/1ps

module vmaRegister
(
   input  logic                 clk,
   input  logic                 rst,
   input  logic                 load,
   input  logic                 fromDp,
   input  logic                 sweepIn,
   input  logic                 extendedIn,
   input  ksMemPkg::dpWordT     dp,
   input  ksMemPkg::ctxFlagsT   ctxUcode,
   output ksMemPkg::vmaAddrT    vmaAddr,
   output logic                 vmaSweep,
   output logic                 vmaExtended,
   output ksMemPkg::ctxFlagsT   ctx
);

   import ksMemPkg::*;

   ctxFlagsT ctxDp;
   ctxFlagsT ctxNext;

   //////////////////////////////////////////////////////////////////////
   // Context source select
   //////////////////////////////////////////////////////////////////////

   // Flag view of the data path word
   always_comb
   begin
      ctxDp.user        = dp.fields.flags.user;
      ctxDp.fetch       = dp.fields.flags.fetch;
      ctxDp.physical    = dp.fields.flags.physical;
      ctxDp.previous    = dp.fields.flags.previous;
      ctxDp.ioCycle     = dp.fields.flags.ioCycle;
      ctxDp.wruCycle    = dp.fields.flags.wruCycle;
      ctxDp.vectorCycle = dp.fields.flags.vectorCycle;
      ctxDp.ioByteCycle = dp.fields.flags.ioByteCycle;
   end

   assign ctxNext = fromDp ? ctxDp : ctxUcode;

   //////////////////////////////////////////////////////////////////////
   // Register
   //////////////////////////////////////////////////////////////////////

   always_ff @(posedge clk or posedge rst)
   begin
      if (rst)
      begin
         vmaAddr     <= '0;
         vmaSweep    <= 1'b0;
         vmaExtended <= 1'b0;
         ctx         <= '0;
      end
      else if (load)
      begin
         // Address always comes from the data path
         vmaAddr     <= dp.fields.addr;
         vmaSweep    <= sweepIn;
         vmaExtended <= extendedIn;
         ctx         <= ctxNext;
      end
   end

endmodule

/* src/vmaUnit.sv */
// VMA stage top level: control decode, VMA and cycle registers, flag word assembly
`timescale 1ns/1ps

module vmaUnit
(
   input  logic                 clk,
   input  logic                 rst,
   input  logic                 clken,
   input  ksMicroPkg::cromT     crom,
   input  ksMicroPkg::dromT     drom,
   input  ksMemPkg::dpWordT     dp,
   input  logic                 cpuExec,
   input  logic                 prevEn,
   input  logic [0:17]          pcFlags,
   output logic                 vmaSweep,
   output logic                 vmaExtended,
   output ksMemPkg::vmaFlagsT   vmaFlags,
   output ksMemPkg::vmaAddrT    vmaAddr
);

   import ksMemPkg::*;

   logic     vmaLoad;
   logic     memLoad;
   logic     ctxFromDp;
   logic     cycleFromDp;
   logic     sweep;
   logic     extended;
   ctxFlagsT ctxUcode;
   ctxFlagsT ctx;
   memCycleT cycleUcode;
   memCycleT cycle;

   // Decode of microword and dispatch word
   vmaControl u_control
   (
      .crom        (crom),
      .drom        (drom),
      .clken       (clken),
      .cpuExec     (cpuExec),
      .prevEn      (prevEn),
      .pcFlags     (pcFlags),
      .vmaLoad     (vmaLoad),
      .memLoad     (memLoad),
      .ctxFromDp   (ctxFromDp),
      .cycleFromDp (cycleFromDp),
      .sweep       (sweep),
      .extended    (extended),
      .ctxUcode    (ctxUcode),
      .cycleUcode  (cycleUcode)
   );

   vmaRegister u_vmaReg
   (
      .clk         (clk),
      .rst         (rst),
      .load        (vmaLoad),
      .fromDp      (ctxFromDp),
      .sweepIn     (sweep),
      .extendedIn  (extended),
      .dp          (dp),
      .ctxUcode    (ctxUcode),
      .vmaAddr     (vmaAddr),
      .vmaSweep    (vmaSweep),
      .vmaExtended (vmaExtended),
      .ctx         (ctx)
   );

   memCycleRegister u_cycleReg
   (
      .clk         (clk),
      .rst         (rst),
      .load        (memLoad),
      .fromDp      (cycleFromDp),
      .dp          (dp),
      .cycleUcode  (cycleUcode),
      .cycle       (cycle)
   );

   //////////////////////////////////////////////////////////////////////
   // Flag word assembly
   //////////////////////////////////////////////////////////////////////

   always_comb
   begin
      vmaFlags.user        = ctx.user;
      vmaFlags.spare1      = 1'b0;
      vmaFlags.fetch       = ctx.fetch;
      vmaFlags.readCycle   = cycle.readCycle;
      vmaFlags.wrTestCycle = cycle.wrTestCycle;
      vmaFlags.writeCycle  = cycle.writeCycle;
      vmaFlags.spare6      = 1'b0;
      vmaFlags.cacheInh    = cycle.cacheInh;
      vmaFlags.physical    = ctx.physical;
      vmaFlags.previous    = ctx.previous;
      // I/O cycle kinds only ever come from the data path
      vmaFlags.ioCycle     = ctx.ioCycle;
      vmaFlags.wruCycle    = ctx.wruCycle;
      vmaFlags.vectorCycle = ctx.vectorCycle;
      vmaFlags.ioByteCycle = ctx.ioByteCycle;
   end

endmodule
